//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP       := sf_user_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/sf_model.svh
`ifndef SF_MODEL_SVH
`define SF_MODEL_SVH

// --------------------
// Reference model
// --------------------

// Constants are Q16 fixed point
localparam int     FRAC   = 16;
localparam longint PW_MAX = (64'sd1 <<< (PW - 1)) - 64'sd1;
localparam longint PW_MIN = -(64'sd1 <<< (PW - 1));

typedef struct packed {
        pair_t              ab;
        pair_t              cd;
        logic [3:0][TW-1:0] raw;
        logic [2:0]         nsat;
} model_t;

// Keep TW bits, sign extended back
function automatic longint to_tw(input longint v);
        logic signed [TW-1:0] t;
        t = TW'(v);
        return longint'(t);
endfunction

// Clamp to the PW range, hit tells whether the value moved
function automatic logic signed [PW-1:0] clamp_pw(input longint v, output logic hit);
        hit = (v > PW_MAX) || (v < PW_MIN);
        if (v > PW_MAX) begin
                return PW'(PW_MAX);
        end
        if (v < PW_MIN) begin
                return PW'(PW_MIN);
        end
        return PW'(v);
endfunction

function automatic model_t model_calc(input logic signed [PW-1:0] k0, k1, k2, k3, meas);
        model_t               m;
        longint               r [4];
        logic                 s [4];
        logic signed [PW-1:0] a;
        logic signed [PW-1:0] b;
        r[0] = to_tw((longint'(k0) * longint'(meas)) >>> FRAC);
        r[1] = to_tw((longint'(k1) * longint'(meas)) >>> FRAC);
        a = clamp_pw(r[0], s[0]);
        b = clamp_pw(r[1], s[1]);
        // c and d work on the clamped a and b
        r[2] = to_tw(((longint'(k2) * longint'(a)) >>> FRAC) + longint'(meas));
        r[3] = to_tw(((longint'(k3) * longint'(b)) >>> FRAC) + longint'(meas));
        m.ab   = '{x: a, y: b};
        m.cd.x = clamp_pw(r[2], s[2]);
        m.cd.y = clamp_pw(r[3], s[3]);
        m.nsat = '0;
        for (int i = 0; i < 4; i++) begin
                m.raw[i] = TW'(r[i]);
                m.nsat   = m.nsat + 3'(s[i]);
        end
        return m;
endfunction

// --------------------
// Compare tasks
// --------------------

task automatic check_pair(input string name, input pair_t got, input pair_t exp);
        if (got !== exp) begin
                $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
                stop_run();
        end
endtask

task automatic check_trace(input logic signed [TW-1:0] got, input logic signed [TW-1:0] exp);
        if (got !== exp) begin
                $display("CHECK FAILED trace_o: got %h expected %h", got, exp);
                stop_run();
        end
endtask

task automatic check_addr(input logic [TAW-1:0] got, input logic [TAW-1:0] exp);
        if (got !== exp) begin
                $display("CHECK FAILED trace_addr_o: got %h expected %h", got, exp);
                stop_run();
        end
endtask

task automatic check_count(input logic [SAT_CW-1:0] got, input logic [SAT_CW-1:0] exp);
        if (got !== exp) begin
                $display("CHECK FAILED sat_count_o: got %h expected %h", got, exp);
                stop_run();
        end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
                $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
                stop_run();
        end
endtask

`endif

//--- bench/sf_user_tb.sv
module sf_user_tb
        import sf_cfg_pkg::*, sf_calc_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int TAW      = 7;
localparam int WAIT_MAX = 40;
localparam int NROWS    = 8;
localparam int NRAND    = 28;

logic                   clk;
logic                   rst_n_i;
logic                   ce_i;
logic                   trigger_i;
logic signed [PW-1:0]   meas_i;
logic                   h_write_i;
const_wr_t              h_wr_i;
logic                   ab_update_o;
pair_t                  ab_o;
logic                   cd_update_o;
pair_t                  cd_o;
logic signed [TW-1:0]   trace_o;
logic [TAW-1:0]         trace_addr_o;
logic                   trace_strobe_o;
logic [SAT_CW-1:0]      sat_count_o;

logic signed [PW-1:0]   cur_k [4];
logic [TAW-1:0]         exp_addr;
int                     exp_sat;
int                     seed;

task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
endtask

`include "sf_model.svh"

typedef struct packed {
        logic signed [PW-1:0] k0, k1, k2, k3;
        logic signed [PW-1:0] meas;
        logic                 collide;
        logic                 frozen;
} row_t;

// Frozen rows try to write their k values with ce_i low, so the old ones stay
row_t rows [NROWS] = '{
        //  k0             k1             k2             k3             meas  col frz
        '{18'sd65536,   18'sd32768,   18'sd16384,   -18'sd32768,  18'sd1000,    1'b0, 1'b0},
        '{-18'sd65536,  18'sd98304,   18'sd49152,   18'sd8192,    -18'sd20000,  1'b1, 1'b0},
        '{18'sd131071,  -18'sd131071, 18'sd131071,  18'sd131071,  18'sd100000,  1'b0, 1'b0},
        '{18'sd7,       18'sd7,       18'sd7,       18'sd7,       -18'sd5000,   1'b0, 1'b1},
        '{18'sd120000,  -18'sd3000,   18'sd70000,   -18'sd90000,  -18'sd131071, 1'b1, 1'b0},
        '{18'sd0,       18'sd0,       18'sd0,       18'sd0,       18'sd131071,  1'b0, 1'b0},
        '{18'sd65535,   18'sd65537,   -18'sd65536,  18'sd65536,   -18'sd131071, 1'b0, 1'b0},
        '{18'sd1,       18'sd2,       18'sd3,       18'sd4,       18'sd77,      1'b0, 1'b1}
};

sf_user_top dut_i (
        .clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i),
        .trigger_i(trigger_i), .meas_i(meas_i),
        .h_write_i(h_write_i), .h_wr_i(h_wr_i),
        .ab_update_o(ab_update_o), .ab_o(ab_o),
        .cd_update_o(cd_update_o), .cd_o(cd_o),
        .trace_o(trace_o), .trace_addr_o(trace_addr_o),
        .trace_strobe_o(trace_strobe_o), .sat_count_o(sat_count_o));

always #4 clk = ~clk;

// --------------------
// Stimulus tasks
// --------------------

task automatic load_consts(input row_t r);
        logic signed [PW-1:0] k [4];
        k = '{r.k0, r.k1, r.k2, r.k3};
        for (int i = 0; i < 4; i++) begin
                @(negedge clk);
                h_write_i = 1'b1;
                h_wr_i    = '{addr: CONST_AW'(i), data: k[i]};
                cur_k[i]  = k[i];
        end
        @(negedge clk);
        h_write_i = 1'b0;
endtask

// Trigger and writes with ce_i low, nothing may move
task automatic freeze_check(input row_t r);
        logic signed [PW-1:0] k [4];
        k = '{r.k0, r.k1, r.k2, r.k3};
        for (int n = 0; n < WAIT_MAX; n++) begin
                @(negedge clk);
                ce_i      = 1'b0;
                trigger_i = (n == 0);
                h_write_i = (n < 4);
                h_wr_i    = '{addr: CONST_AW'(n % 4), data: k[n % 4]};
                if (ab_update_o || cd_update_o || trace_strobe_o) begin
                        $display("An output pulse appeared while ce_i was low");
                        stop_run();
                end
        end
        @(negedge clk);
        ce_i      = 1'b1;
        trigger_i = 1'b0;
        h_write_i = 1'b0;
endtask

task automatic run_trigger(input logic signed [PW-1:0] meas, input logic collide);
        model_t m;
        int     lat;
        int     ntr;
        logic   cd_seen;
        m = model_calc(cur_k[0], cur_k[1], cur_k[2], cur_k[3], meas);
        @(negedge clk);
        trigger_i = 1'b1;
        meas_i    = meas;
        lat       = 0;
        // Colliding writes put the stored k0 and k1 back during the fetch
        while (!ab_update_o) begin
                if (lat == WAIT_MAX) begin
                        $display("Timed out waiting for ab_update_o");
                        stop_run();
                end
                @(negedge clk);
                lat++;
                trigger_i = 1'b0;
                h_write_i = collide && (lat <= 2);
                h_wr_i    = '{addr: CONST_AW'(lat - 1), data: cur_k[(lat - 1) % 4]};
        end
        // 7 cycles from the trigger edge, one more per collision
        if (lat - 1 != (collide ? 9 : 7)) begin
                $display("ab_update_o came %0d cycles after the trigger", lat - 1);
                stop_run();
        end
        check_pair("ab_o", ab_o, m.ab);

        ntr     = 0;
        cd_seen = 1'b0;
        for (int n = 1; !(cd_seen && ntr == 4); n++) begin
                if (n > WAIT_MAX) begin
                        $display("Timed out waiting for cd_update_o and the trace strobes");
                        stop_run();
                end
                @(negedge clk);
                if (cd_update_o) begin
                        if (n != 2) begin
                                $display("cd_update_o came %0d cycles after ab_update_o", n);
                                stop_run();
                        end
                        check_pair("cd_o", cd_o, m.cd);
                        cd_seen = 1'b1;
                end
                if (trace_strobe_o) begin
                        if (ntr == 4) begin
                                $display("More than four trace strobes for one trigger");
                                stop_run();
                        end
                        check_trace(trace_o, m.raw[ntr]);
                        check_addr(trace_addr_o, exp_addr);
                        exp_addr++;
                        ntr++;
                end
        end

        exp_sat = exp_sat + int'(m.nsat);
        if (exp_sat > (2 ** SAT_CW) - 1) begin
                exp_sat = (2 ** SAT_CW) - 1;
        end
        check_count(sat_count_o, SAT_CW'(exp_sat));
endtask

// --------------------
// Main sequence
// --------------------

initial begin
        logic [31:0] rnd;
        clk       = 1'b0;
        rst_n_i   = 1'b0;
        ce_i      = 1'b1;
        trigger_i = 1'b0;
        meas_i    = '0;
        h_write_i = 1'b0;
        h_wr_i    = '0;
        exp_addr  = '0;
        exp_sat   = 0;
        seed      = 32'hcc87;
        for (int i = 0; i < 4; i++) begin
                cur_k[i] = '0;
        end

        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;

        // Reset values
        check_flag("ab_update_o", ab_update_o, 1'b0);
        check_flag("cd_update_o", cd_update_o, 1'b0);
        check_flag("trace_strobe_o", trace_strobe_o, 1'b0);
        check_pair("ab_o", ab_o, '0);
        check_pair("cd_o", cd_o, '0);
        check_addr(trace_addr_o, '0);
        check_count(sat_count_o, '0);

        for (int r = 0; r < NROWS; r++) begin
                if (rows[r].frozen) begin
                        freeze_check(rows[r]);
                end else begin
                        load_consts(rows[r]);
                end
                run_trigger(rows[r].meas, rows[r].collide);
        end

        // Random measurements on the last constants, enough to wrap the trace address
        for (int r = 0; r < NRAND; r++) begin
                rnd = $random(seed);
                run_trigger(rnd[PW-1:0], rnd[31]);
        end

        $display("Simulation finished: PASS");
        $finish;
end

endmodule

//--- files.f
+incdir+bench
rtl/sf_cfg_pkg.sv
rtl/sf_calc_pkg.sv
rtl/sf_const_ram.sv
rtl/sf_const_arbiter.sv
rtl/sf_engine.sv
rtl/sf_trace.sv
rtl/sf_user_top.sv
bench/sf_user_tb.sv

//--- rtl/sf_calc_pkg.sv
// Computation side of the state-feedback block
package sf_calc_pkg;

import sf_cfg_pkg::*;

// --------------------
// Widths
// --------------------

// Guard bits carried on the trace word
localparam int EXTRA = 4;
localparam int TW    = PW + EXTRA;

// Saturation counter width
localparam int SAT_CW = 7;

// Signed PW-bit range, expressed at trace width
localparam logic signed [TW-1:0] SAT_MAX = TW'((2 ** (PW - 1)) - 1);
localparam logic signed [TW-1:0] SAT_MIN = TW'(-(2 ** (PW - 1)));

// --------------------
// Types
// --------------------

typedef enum logic [2:0] {
        IDLE,
        FETCH,
        CALC_AB,
        CALC_CD,
        DONE
} eng_state_e;

// Used for both the a/b and the c/d outputs
typedef struct packed {
        logic signed [PW-1:0] x;
        logic signed [PW-1:0] y;
} pair_t;

// Raw intermediate before saturation
typedef struct packed {
        logic signed [TW-1:0] data;
        logic                 sat;
} trace_rec_t;

endpackage

//--- rtl/sf_cfg_pkg.sv
// Constant memory side of the state-feedback block
package sf_cfg_pkg;

// --------------------
// Widths
// --------------------

// Constants, measurement and outputs share one signed width
localparam int PW = 18;

// Four constants k0..k3
localparam int CONST_AW = 2;

// --------------------
// Host write port
// --------------------

// Plain strobe write, no handshake
typedef struct packed {
        logic        [CONST_AW-1:0] addr;
        logic signed [PW-1:0]       data;
} const_wr_t;

endpackage

//--- rtl/sf_const_arbiter.sv
module sf_const_arbiter
        import sf_cfg_pkg::*;
(
        input  logic                       clk,
        input  logic                       rst_n_i,
        input  logic                       ce_i,

        // Host write path
        input  logic                       h_write_i,
        input  const_wr_t                  h_wr_i,

        // Engine read path
        input  logic                       rd_req_i,
        input  logic        [CONST_AW-1:0] rd_addr_i,
        output logic                       rd_gnt_o,

        // Merged RAM port
        output logic        [CONST_AW-1:0] ram_addr_o,
        output logic                       ram_we_o,
        output logic signed [PW-1:0]       ram_wdata_o
);

logic host_sel;

// Host writes only count while the clock enable is high
assign host_sel = ce_i && h_write_i;

// --------------------
// Port mux
// --------------------

// Fixed priority: a host write always takes the port
assign ram_we_o    = host_sel;
assign ram_addr_o  = h_write_i ? h_wr_i.addr : rd_addr_i;
assign ram_wdata_o = h_wr_i.data;

// Engine gets the port in any cycle the host leaves free
assign rd_gnt_o = ce_i && rd_req_i && !h_write_i;

// --------------------
// Checks
// --------------------

a_one_owner: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(rd_gnt_o && ram_we_o)
) else $error("arbiter: read grant and host write in the same cycle");

// A refused request must stay up with the same address
a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        rd_req_i && !rd_gnt_o |=> rd_req_i && $stable(rd_addr_i)
) else $error("arbiter: engine dropped or moved a pending read");

endmodule

//--- rtl/sf_const_ram.sv
module sf_const_ram
        import sf_cfg_pkg::*;
(
        input  logic                       clk,
        input  logic                       ce_i,
        input  logic        [CONST_AW-1:0] addr_i,
        input  logic                       we_i,
        input  logic signed [PW-1:0]       wdata_i,
        output logic signed [PW-1:0]       rdata_o
);

localparam int DEPTH = 2 ** CONST_AW;

logic signed [PW-1:0] mem [DEPTH];

// Single port, write has priority on the array
always_ff @(posedge clk) begin
        if (ce_i && we_i) begin
                mem[addr_i] <= wdata_i;
        end
end

// Registered read, data shows up one cycle after the address
// (read-before-write on a colliding address)
always_ff @(posedge clk) begin
        if (ce_i) begin
                rdata_o <= mem[addr_i];
        end
end

endmodule

//--- rtl/sf_engine.sv
module sf_engine
        import sf_cfg_pkg::*, sf_calc_pkg::*;
#(
        parameter int FRAC_SHIFT = 16
) (
        input  logic                       clk,
        input  logic                       rst_n_i,
        input  logic                       ce_i,
        input  logic                       trigger_i,
        input  logic signed [PW-1:0]       meas_i,

        // Constant read through the arbiter
        output logic                       rd_req_o,
        output logic        [CONST_AW-1:0] rd_addr_o,
        input  logic                       rd_gnt_i,
        input  logic signed [PW-1:0]       rd_data_i,

        output logic                       ab_update_o,
        output pair_t                      ab_o,
        output logic                       cd_update_o,
        output pair_t                      cd_o,
        output logic                       trace_valid_o,
        output trace_rec_t                 trace_o
);

localparam int RW = 2 * PW + 1;

eng_state_e           state_q;
logic                 step_q;
logic [CONST_AW:0]    rd_idx_q;
logic                 rd_vld_q;

logic signed [PW-1:0]   meas_q;
logic signed [PW-1:0]   k_q [2 ** CONST_AW];
logic signed [2*PW-1:0] prod_x_q;
logic signed [2*PW-1:0] prod_y_q;
trace_rec_t             hold_q;

logic signed [PW-1:0] coef_x, coef_y;
logic signed [PW-1:0] op_x, op_y;
logic signed [PW-1:0] add_v;
trace_rec_t           rec_x, rec_y;

// Shift, add, keep TW bits and flag values outside the PW range
function automatic trace_rec_t mk_rec(input logic signed [2*PW-1:0] prod,
                                      input logic signed [PW-1:0]   add);
        logic signed [RW-1:0] raw;
        trace_rec_t           rec;
        raw = (RW'(prod) >>> FRAC_SHIFT) + RW'(add);
        rec.data = raw[TW-1:0];
        rec.sat  = ($signed(rec.data) > SAT_MAX) || ($signed(rec.data) < SAT_MIN);
        return rec;
endfunction

function automatic logic signed [PW-1:0] to_pw(input trace_rec_t rec);
        if (!rec.sat) begin
                return rec.data[PW-1:0];
        end
        return rec.data[TW-1] ? SAT_MIN[PW-1:0] : SAT_MAX[PW-1:0];
endfunction

// --------------------
// Fetch
// --------------------

// Index bit CONST_AW marks all four reads granted
assign rd_req_o  = (state_q == FETCH) && !rd_idx_q[CONST_AW];
assign rd_addr_o = rd_idx_q[CONST_AW-1:0];

// --------------------
// Datapath
// --------------------

// a/b use k0,k1 on meas; c/d use k2,k3 on the saturated a,b
always_comb begin
        if (state_q == CALC_CD) begin
                coef_x = k_q[2];
                coef_y = k_q[3];
                op_x   = ab_o.x;
                op_y   = ab_o.y;
                add_v  = meas_q;
        end else begin
                coef_x = k_q[0];
                coef_y = k_q[1];
                op_x   = meas_q;
                op_y   = meas_q;
                add_v  = '0;
        end
end

assign rec_x = mk_rec(prod_x_q, add_v);
assign rec_y = mk_rec(prod_y_q, add_v);

always_ff @(posedge clk) begin
        if (ce_i) begin
                if (state_q == IDLE && trigger_i) begin
                        meas_q <= meas_i;
                end
                // Read data belongs to the address before the current index
                if (rd_vld_q) begin
                        k_q[rd_idx_q[CONST_AW-1:0] - 1'b1] <= rd_data_i;
                end
                if (!step_q) begin
                        prod_x_q <= coef_x * op_x;
                        prod_y_q <= coef_y * op_y;
                end
                // Second record of a pair waits one cycle in hold_q
                if (step_q) begin
                        trace_o <= rec_x;
                        hold_q  <= rec_y;
                end else begin
                        trace_o <= hold_q;
                end
        end
end

// --------------------
// Sequencer
// --------------------

always_ff @(posedge clk) begin
        if (!rst_n_i) begin
                state_q       <= IDLE;
                step_q        <= 1'b0;
                rd_idx_q      <= '0;
                rd_vld_q      <= 1'b0;
                ab_update_o   <= 1'b0;
                cd_update_o   <= 1'b0;
                ab_o          <= '0;
                cd_o          <= '0;
                trace_valid_o <= 1'b0;
        end else if (ce_i) begin
                ab_update_o   <= 1'b0;
                cd_update_o   <= 1'b0;
                trace_valid_o <= 1'b0;
                rd_vld_q      <= rd_gnt_i;
                case (state_q)
                IDLE: begin
                        if (trigger_i) begin
                                rd_idx_q <= '0;
                                state_q  <= FETCH;
                        end
                end
                FETCH: begin
                        if (rd_gnt_i) begin
                                rd_idx_q <= rd_idx_q + 1'b1;
                        end
                        // Leave once k3 has landed
                        if (rd_vld_q && rd_idx_q[CONST_AW]) begin
                                state_q <= CALC_AB;
                        end
                end
                CALC_AB: begin
                        step_q <= !step_q;
                        if (step_q) begin
                                ab_o          <= '{x: to_pw(rec_x), y: to_pw(rec_y)};
                                ab_update_o   <= 1'b1;
                                trace_valid_o <= 1'b1;
                                state_q       <= CALC_CD;
                        end
                end
                CALC_CD: begin
                        step_q        <= !step_q;
                        trace_valid_o <= 1'b1;
                        if (step_q) begin
                                cd_o        <= '{x: to_pw(rec_x), y: to_pw(rec_y)};
                                cd_update_o <= 1'b1;
                                state_q     <= DONE;
                        end
                end
                DONE: begin
                        // Last trace record (d)
                        trace_valid_o <= 1'b1;
                        state_q       <= IDLE;
                end
                default: state_q <= IDLE;
                endcase
        end
end

// --------------------
// Checks
// --------------------

a_ab_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ab_update_o && ce_i |=> !ab_update_o
) else $error("engine: ab_update_o longer than one cycle");

a_cd_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        cd_update_o && ce_i |=> !cd_update_o
) else $error("engine: cd_update_o longer than one cycle");

a_cd_after_ab: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (ab_update_o && ce_i) ##1 ce_i |=> cd_update_o
) else $error("engine: cd_update_o not 2 cycles after ab_update_o");

endmodule

//--- rtl/sf_trace.sv
module sf_trace
        import sf_calc_pkg::*;
#(
        parameter int TRACE_AW = 7
) (
        input  logic                       clk,
        input  logic                       rst_n_i,
        input  logic                       ce_i,
        input  logic                       trace_valid_i,
        input  trace_rec_t                 trace_i,
        output logic signed [TW-1:0]       trace_o,
        output logic        [TRACE_AW-1:0] trace_addr_o,
        output logic                       trace_strobe_o,
        output logic        [SAT_CW-1:0]   sat_count_o
);

// Trace word follows the record by one cycle
always_ff @(posedge clk) begin
        if (ce_i && trace_valid_i) begin
                trace_o <= trace_i.data;
        end
end

always_ff @(posedge clk) begin
        if (!rst_n_i) begin
                trace_strobe_o <= 1'b0;
                trace_addr_o   <= '0;
                sat_count_o    <= '0;
        end else if (ce_i) begin
                trace_strobe_o <= trace_valid_i;
                // Address moves on once the strobe has been seen, wraps freely
                if (trace_strobe_o) begin
                        trace_addr_o <= trace_addr_o + 1'b1;
                end
                // Sticks at all ones
                if (trace_valid_i && trace_i.sat && !(&sat_count_o)) begin
                        sat_count_o <= sat_count_o + 1'b1;
                end
        end
end

a_count_up: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        1'b1 |=> sat_count_o >= $past(sat_count_o)
) else $error("trace: saturation count went down");

endmodule

//--- rtl/sf_user_top.sv
module sf_user_top
        import sf_cfg_pkg::*, sf_calc_pkg::*;
#(
        parameter int FRAC_SHIFT = 16,
        parameter int TRACE_AW   = 7
) (
        input  logic                       clk,
        input  logic                       rst_n_i,
        input  logic                       ce_i,
        input  logic                       trigger_i,
        input  logic signed [PW-1:0]       meas_i,
        input  logic                       h_write_i,
        input  const_wr_t                  h_wr_i,
        output logic                       ab_update_o,
        output pair_t                      ab_o,
        output logic                       cd_update_o,
        output pair_t                      cd_o,
        output logic signed [TW-1:0]       trace_o,
        output logic        [TRACE_AW-1:0] trace_addr_o,
        output logic                       trace_strobe_o,
        output logic        [SAT_CW-1:0]   sat_count_o
);

logic                       rd_req;
logic        [CONST_AW-1:0] rd_addr;
logic                       rd_gnt;
logic signed [PW-1:0]       rd_data;
logic        [CONST_AW-1:0] ram_addr;
logic                       ram_we;
logic signed [PW-1:0]       ram_wdata;
logic                       trace_valid;
trace_rec_t                 trace_rec;

// Host and engine share the single RAM port
sf_const_arbiter i_arb (
        .clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i),
        .h_write_i(h_write_i), .h_wr_i(h_wr_i),
        .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_gnt_o(rd_gnt),
        .ram_addr_o(ram_addr), .ram_we_o(ram_we), .ram_wdata_o(ram_wdata));

sf_const_ram i_ram (
        .clk(clk), .ce_i(ce_i),
        .addr_i(ram_addr), .we_i(ram_we), .wdata_i(ram_wdata),
        .rdata_o(rd_data));

sf_engine #(.FRAC_SHIFT(FRAC_SHIFT)) i_engine (
        .clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i),
        .trigger_i(trigger_i), .meas_i(meas_i),
        .rd_req_o(rd_req), .rd_addr_o(rd_addr),
        .rd_gnt_i(rd_gnt), .rd_data_i(rd_data),
        .ab_update_o(ab_update_o), .ab_o(ab_o),
        .cd_update_o(cd_update_o), .cd_o(cd_o),
        .trace_valid_o(trace_valid), .trace_o(trace_rec));

sf_trace #(.TRACE_AW(TRACE_AW)) i_trace (
        .clk(clk), .rst_n_i(rst_n_i), .ce_i(ce_i),
        .trace_valid_i(trace_valid), .trace_i(trace_rec),
        .trace_o(trace_o), .trace_addr_o(trace_addr_o),
        .trace_strobe_o(trace_strobe_o), .sat_count_o(sat_count_o));

endmodule
